// File: source/dbg_defs.svh
// Shared widths and message sizes of the serial debug reporter
// Field widths are tied to the fixed digit counts of the report lines
// Changing a width needs a matching change in the formatter
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// ============================================================
// UART timing
// ============================================================
`define DBG_CLKS_PER_BIT   443    // 51 MHz / 115200 baud

// ============================================================
// Field widths
// ============================================================
`define DBG_FRAME_W        16     // Frame number and valid count
`define DBG_PC_W           12     // CPU program counter
`define DBG_INSTR_W        16     // Instruction count
`define DBG_PIXCNT_W       20     // Pixel count, 5 hex digits
`define DBG_COORD_W        10     // X and Y, 3 hex digits
`define DBG_BRIGHT_W       3      // Brightness, 1 hex digit

// Line lengths including CR LF
`define DBG_FRAME_MSG_LEN  31
`define DBG_PIXEL_MSG_LEN  25

`endif

// File: source/dbg_pkg.sv
// Snapshot payloads carried from capture to the message formatter
// Field order has no meaning on the wire, the formatter picks fields by name
`include "dbg_defs.svh"

package dbg_pkg;

    // Frame report, 61 bits
    typedef struct packed {
        logic [`DBG_FRAME_W-1:0] frame;      // Frame number before increment
        logic [`DBG_PC_W-1:0]    pc;
        logic [`DBG_INSTR_W-1:0] instr;
        logic [`DBG_FRAME_W-1:0] valid_cnt;  // Valid-pixel cycles in the frame
        logic                    running;    // CPU running flag
    } frame_snap_t;

    // Pixel report, 43 bits
    typedef struct packed {
        logic [`DBG_PIXCNT_W-1:0] count;
        logic [`DBG_COORD_W-1:0]  x;
        logic [`DBG_COORD_W-1:0]  y;
        logic [`DBG_BRIGHT_W-1:0] bright;
    } pixel_snap_t;

endpackage

// File: source/frame_stats.sv
// Event capture for frame and pixel reports
// Fires on rising edges only, so a tick held high reports once
// Frame and valid counters wrap silently at DBG_FRAME_W bits
`timescale 1ns/10ps
`include "dbg_defs.svh"

module frame_stats (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_frame_tick,
    input  logic                     i_pixel_valid,
    input  logic [`DBG_PC_W-1:0]     i_cpu_pc,
    input  logic [`DBG_INSTR_W-1:0]  i_cpu_instr_count,
    input  logic                     i_cpu_running,
    input  logic                     i_pixel_strobe,
    input  logic [`DBG_PIXCNT_W-1:0] i_pixel_count,
    input  logic [`DBG_COORD_W-1:0]  i_pixel_x,
    input  logic [`DBG_COORD_W-1:0]  i_pixel_y,
    input  logic [`DBG_BRIGHT_W-1:0] i_pixel_brightness,
    output logic                     o_frame_cap,   // One cycle after tick edge
    output dbg_pkg::frame_snap_t     o_frame_snap,
    output logic                     o_pixel_cap,   // One cycle after strobe edge
    output dbg_pkg::pixel_snap_t     o_pixel_snap
);

    logic                    r_frame_tick_d;
    logic                    r_pixel_strobe_d;
    logic [`DBG_FRAME_W-1:0] r_frame_cnt;
    logic [`DBG_FRAME_W-1:0] r_valid_cnt;   // Valid cycles since last capture
    logic                    w_frame_rise;
    logic                    w_pixel_rise;

    assign w_frame_rise = i_frame_tick & ~r_frame_tick_d;
    assign w_pixel_rise = i_pixel_strobe & ~r_pixel_strobe_d;

    // Edge history, counters and strobes
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_frame_tick_d   <= 1'b0;
            r_pixel_strobe_d <= 1'b0;
            r_frame_cnt      <= '0;
            r_valid_cnt      <= '0;
            o_frame_cap      <= 1'b0;
            o_pixel_cap      <= 1'b0;
        end else begin
            r_frame_tick_d   <= i_frame_tick;
            r_pixel_strobe_d <= i_pixel_strobe;
            o_frame_cap      <= w_frame_rise;
            o_pixel_cap      <= w_pixel_rise;
            if (w_frame_rise) begin
                r_frame_cnt <= r_frame_cnt + 1'b1;
                // Capture cycle already belongs to the next frame
                r_valid_cnt <= {{(`DBG_FRAME_W-1){1'b0}}, i_pixel_valid};
            end else if (i_pixel_valid) begin
                r_valid_cnt <= r_valid_cnt + 1'b1;
            end
        end
    end

    // Payloads sampled in the edge cycle, valid with the strobe
    always_ff @(posedge i_clk) begin
        if (w_frame_rise) begin
            o_frame_snap.frame     <= r_frame_cnt;   // Old value, first report 0000
            o_frame_snap.pc        <= i_cpu_pc;
            o_frame_snap.instr     <= i_cpu_instr_count;
            o_frame_snap.valid_cnt <= r_valid_cnt;
            o_frame_snap.running   <= i_cpu_running;
        end
        if (w_pixel_rise) begin
            o_pixel_snap.count  <= i_pixel_count;
            o_pixel_snap.x      <= i_pixel_x;
            o_pixel_snap.y      <= i_pixel_y;
            o_pixel_snap.bright <= i_pixel_brightness;
        end
    end

endmodule

// File: source/snapshot_slot.sv
// Single-entry holding register between capture and formatter
// Newer captures overwrite the held payload until ack rises
// Captures arriving while ack is high are lost
`timescale 1ns/10ps

module snapshot_slot #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_cap,     // Capture strobe, no back-pressure
    input  payload_t i_data,
    input  logic     i_ack,     // Formatter has copied o_data
    output logic     o_req,     // Payload waiting
    output payload_t o_data
);

    // Four-phase request side
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_req <= 1'b0;
        end else if (i_ack) begin
            o_req <= 1'b0;          // Taken, wait for ack to fall
        end else if (i_cap) begin
            o_req <= 1'b1;
        end
    end

    // Latest capture wins
    always_ff @(posedge i_clk) begin
        if (i_cap && !i_ack) begin
            o_data <= i_data;
        end
    end

endmodule

// File: source/msg_formatter.sv
// Turns held snapshots into ASCII hex lines, one byte handshake per char
// Pixel reports win over frame reports when both wait
// Enable is sampled when a report is taken, a line in flight always completes
`timescale 1ns/10ps
`include "dbg_defs.svh"

module msg_formatter (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_enable,
    input  logic                 i_frame_req,
    input  dbg_pkg::frame_snap_t i_frame_data,
    input  logic                 i_pixel_req,
    input  dbg_pkg::pixel_snap_t i_pixel_data,
    input  logic                 i_byte_ack,
    output logic                 o_frame_ack,
    output logic                 o_pixel_ack,
    output logic                 o_byte_req,
    output logic [7:0]           o_byte
);

    localparam int FRAME_LEN = `DBG_FRAME_MSG_LEN;
    localparam int PIXEL_LEN = `DBG_PIXEL_MSG_LEN;
    localparam int IDX_W     = $clog2(FRAME_LEN);
    localparam logic [IDX_W-1:0] FRAME_LAST = IDX_W'(FRAME_LEN - 1);
    localparam logic [IDX_W-1:0] PIXEL_LAST = IDX_W'(PIXEL_LEN - 1);

    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for a slot request
        ST_TAKE,    // Ack high, waiting for slot req to fall
        ST_SEND,    // Byte req high, waiting for UART ack
        ST_DROP     // Byte req low, waiting for UART ack to fall
    } state_t;

    state_t                 r_state;
    logic                   r_is_pix;    // Current line is a pixel report
    logic                   r_send;      // Enable at take time
    logic [IDX_W-1:0]       r_idx;       // Character being handed over
    logic [8*FRAME_LEN-1:0] r_line;      // First char in the top byte

    // ============================================================
    // Line building
    // ============================================================
    function automatic logic [7:0] hex_char(input logic [3:0] n);
        return (n < 4'd10) ? 8'h30 + {4'h0, n} : 8'h37 + {4'h0, n};  // 0-9, A-F
    endfunction

    // "F:hhhh PC:hhh I:hhhh V:hhhh R" CR LF
    function automatic logic [8*FRAME_LEN-1:0] frame_line(input dbg_pkg::frame_snap_t s);
        return {"F:",
                hex_char(s.frame[15:12]), hex_char(s.frame[11:8]),
                hex_char(s.frame[7:4]), hex_char(s.frame[3:0]),
                " PC:", hex_char(s.pc[11:8]), hex_char(s.pc[7:4]), hex_char(s.pc[3:0]),
                " I:",
                hex_char(s.instr[15:12]), hex_char(s.instr[11:8]),
                hex_char(s.instr[7:4]), hex_char(s.instr[3:0]),
                " V:",
                hex_char(s.valid_cnt[15:12]), hex_char(s.valid_cnt[11:8]),
                hex_char(s.valid_cnt[7:4]), hex_char(s.valid_cnt[3:0]),
                " ", s.running ? "R" : ".", 8'h0D, 8'h0A};
    endfunction

    // "P:hhhhh X:hhh Y:hhh B:h" CR LF
    function automatic logic [8*PIXEL_LEN-1:0] pixel_line(input dbg_pkg::pixel_snap_t s);
        return {"P:",
                hex_char(s.count[19:16]), hex_char(s.count[15:12]),
                hex_char(s.count[11:8]), hex_char(s.count[7:4]), hex_char(s.count[3:0]),
                " X:", hex_char({2'b00, s.x[9:8]}), hex_char(s.x[7:4]), hex_char(s.x[3:0]),
                " Y:", hex_char({2'b00, s.y[9:8]}), hex_char(s.y[7:4]), hex_char(s.y[3:0]),
                " B:", hex_char({1'b0, s.bright}), 8'h0D, 8'h0A};
    endfunction

    // Held stable from req rise to ack, since r_idx moves only after ack
    assign o_byte = r_line[8*(FRAME_LEN - 1 - int'(r_idx)) +: 8];

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state     <= ST_IDLE;
            r_is_pix    <= 1'b0;
            r_send      <= 1'b0;
            r_idx       <= '0;
            o_frame_ack <= 1'b0;
            o_pixel_ack <= 1'b0;
            o_byte_req  <= 1'b0;
        end else begin
            case (r_state)
                ST_IDLE: begin
                    r_send <= i_enable;    // Low means take and discard
                    if (i_pixel_req) begin
                        o_pixel_ack <= 1'b1;
                        r_is_pix    <= 1'b1;
                        r_state     <= ST_TAKE;
                    end else if (i_frame_req) begin
                        o_frame_ack <= 1'b1;
                        r_is_pix    <= 1'b0;
                        r_state     <= ST_TAKE;
                    end
                end
                ST_TAKE: begin
                    if (!(r_is_pix ? i_pixel_req : i_frame_req)) begin
                        o_pixel_ack <= 1'b0;
                        o_frame_ack <= 1'b0;
                        r_idx       <= '0;
                        o_byte_req  <= r_send;
                        r_state     <= r_send ? ST_SEND : ST_IDLE;
                    end
                end
                ST_SEND: begin
                    if (i_byte_ack) begin
                        o_byte_req <= 1'b0;
                        r_state    <= ST_DROP;
                    end
                end
                ST_DROP: begin
                    if (!i_byte_ack) begin
                        if (r_idx == (r_is_pix ? PIXEL_LAST : FRAME_LAST)) begin
                            r_state <= ST_IDLE;       // Line done
                        end else begin
                            r_idx      <= r_idx + 1'b1;
                            o_byte_req <= 1'b1;
                            r_state    <= ST_SEND;
                        end
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    // Character buffer, loaded when a report is taken
    always_ff @(posedge i_clk) begin
        if (r_state == ST_IDLE) begin
            if (i_pixel_req) begin
                r_line <= {pixel_line(i_pixel_data), {(8*(FRAME_LEN-PIXEL_LEN)){1'b0}}};
            end else if (i_frame_req) begin
                r_line <= frame_line(i_frame_data);
            end
        end
    end

endmodule

// File: source/uart_tx.sv
// 8N1 transmitter, each byte takes exactly 10 x CLKS_PER_BIT cycles
// Ack rises in the cycle the start bit begins
// A new byte is accepted only after the stop bit and the previous ack fall
`timescale 1ns/10ps
`include "dbg_defs.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `DBG_CLKS_PER_BIT
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_byte_req,
    input  logic [7:0] i_byte,
    output logic       o_byte_ack,
    output logic       o_tx          // Idles high
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} state_t;

    state_t           r_state;
    logic [CNT_W-1:0] r_baud_cnt;    // Cycles within the current bit
    logic [2:0]       r_bit_idx;     // Data bit on the line
    logic [7:0]       r_shift;       // Remaining data bits, LSB next
    logic             w_bit_end;

    assign w_bit_end = (r_baud_cnt == CNT_MAX);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state    <= ST_IDLE;
            r_baud_cnt <= '0;
            r_bit_idx  <= '0;
            o_byte_ack <= 1'b0;
            o_tx       <= 1'b1;
        end else begin
            if (o_byte_ack && !i_byte_req) begin
                o_byte_ack <= 1'b0;              // Phase four
            end
            r_baud_cnt <= (r_state == ST_IDLE || w_bit_end) ? '0 : r_baud_cnt + 1'b1;
            case (r_state)
                ST_IDLE: begin
                    if (i_byte_req && !o_byte_ack) begin
                        o_byte_ack <= 1'b1;
                        o_tx       <= 1'b0;      // Start bit begins now
                        r_state    <= ST_START;
                    end
                end
                ST_START: begin
                    if (w_bit_end) begin
                        o_tx      <= r_shift[0];
                        r_bit_idx <= '0;
                        r_state   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (w_bit_end) begin
                        if (r_bit_idx == 3'd7) begin
                            o_tx    <= 1'b1;     // Stop bit
                            r_state <= ST_STOP;
                        end else begin
                            o_tx      <= r_shift[1];
                            r_bit_idx <= r_bit_idx + 1'b1;
                        end
                    end
                end
                ST_STOP: begin
                    if (w_bit_end) begin
                        r_state <= ST_IDLE;
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    // Data shifter, loaded at accept and stepped at each data bit end
    always_ff @(posedge i_clk) begin
        if (r_state == ST_IDLE && i_byte_req && !o_byte_ack) begin
            r_shift <= i_byte;
        end else if (r_state == ST_DATA && w_bit_end) begin
            r_shift <= {1'b0, r_shift[7:1]};
        end
    end

endmodule

// File: source/serial_debug.sv
// Serial debug reporter top level
// Pipeline of capture, snapshot slots, formatter and UART transmitter
// CLKS_PER_BIT sets the baud rate from the system clock
`timescale 1ns/10ps
`include "dbg_defs.svh"

module serial_debug #(
    parameter int CLKS_PER_BIT = `DBG_CLKS_PER_BIT
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_enable,         // Low discards reports
    input  logic                     i_frame_tick,
    input  logic                     i_pixel_valid,
    input  logic [`DBG_PC_W-1:0]     i_cpu_pc,
    input  logic [`DBG_INSTR_W-1:0]  i_cpu_instr_count,
    input  logic                     i_cpu_running,
    input  logic                     i_pixel_strobe,
    input  logic [`DBG_PIXCNT_W-1:0] i_pixel_count,
    input  logic [`DBG_COORD_W-1:0]  i_pixel_x,
    input  logic [`DBG_COORD_W-1:0]  i_pixel_y,
    input  logic [`DBG_BRIGHT_W-1:0] i_pixel_brightness,
    output logic                     o_uart_tx
);

    // ============================================================
    // Stage links
    // ============================================================
    logic                 w_frame_cap;
    dbg_pkg::frame_snap_t w_frame_snap;
    logic                 w_pixel_cap;
    dbg_pkg::pixel_snap_t w_pixel_snap;
    logic                 w_frame_req;
    logic                 w_frame_ack;
    dbg_pkg::frame_snap_t w_frame_data;
    logic                 w_pixel_req;
    logic                 w_pixel_ack;
    dbg_pkg::pixel_snap_t w_pixel_data;
    logic                 w_byte_req;
    logic                 w_byte_ack;
    logic [7:0]           w_byte;

    frame_stats u_frame_stats (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_frame_tick       (i_frame_tick),
        .i_pixel_valid      (i_pixel_valid),
        .i_cpu_pc           (i_cpu_pc),
        .i_cpu_instr_count  (i_cpu_instr_count),
        .i_cpu_running      (i_cpu_running),
        .i_pixel_strobe     (i_pixel_strobe),
        .i_pixel_count      (i_pixel_count),
        .i_pixel_x          (i_pixel_x),
        .i_pixel_y          (i_pixel_y),
        .i_pixel_brightness (i_pixel_brightness),
        .o_frame_cap        (w_frame_cap),
        .o_frame_snap       (w_frame_snap),
        .o_pixel_cap        (w_pixel_cap),
        .o_pixel_snap       (w_pixel_snap)
    );

    // One slot per report type
    snapshot_slot #(.payload_t(dbg_pkg::frame_snap_t)) u_frame_slot (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cap   (w_frame_cap),
        .i_data  (w_frame_snap),
        .i_ack   (w_frame_ack),
        .o_req   (w_frame_req),
        .o_data  (w_frame_data)
    );

    snapshot_slot #(.payload_t(dbg_pkg::pixel_snap_t)) u_pixel_slot (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cap   (w_pixel_cap),
        .i_data  (w_pixel_snap),
        .i_ack   (w_pixel_ack),
        .o_req   (w_pixel_req),
        .o_data  (w_pixel_data)
    );

    msg_formatter u_msg_formatter (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_enable     (i_enable),
        .i_frame_req  (w_frame_req),
        .i_frame_data (w_frame_data),
        .i_pixel_req  (w_pixel_req),
        .i_pixel_data (w_pixel_data),
        .i_byte_ack   (w_byte_ack),
        .o_frame_ack  (w_frame_ack),
        .o_pixel_ack  (w_pixel_ack),
        .o_byte_req   (w_byte_req),
        .o_byte       (w_byte)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_byte_req (w_byte_req),
        .i_byte     (w_byte),
        .o_byte_ack (w_byte_ack),
        .o_tx       (o_uart_tx)
    );

endmodule

// File: sim/tb_serial_debug.sv
// Testbench for the serial debug reporter, run at 8 clocks per UART bit
// Expected lines come from the driven stimulus and a table-based hex rule
// Any report that never completes is caught by the cycle watchdog
`timescale 1ns/10ps
`include "dbg_defs.svh"

module tb_serial_debug;

    localparam int CLKS_PER_BIT   = 8;
    localparam int TIMEOUT_CYCLES = 40000;  // ~6 lines x 31 bytes x 80 cycles, plus margin

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     enable;
    logic                     frame_tick;
    logic                     pixel_valid;
    logic [`DBG_PC_W-1:0]     cpu_pc;
    logic [`DBG_INSTR_W-1:0]  cpu_instr_count;
    logic                     cpu_running;
    logic                     pixel_strobe;
    logic [`DBG_PIXCNT_W-1:0] pixel_count;
    logic [`DBG_COORD_W-1:0]  pixel_x;
    logic [`DBG_COORD_W-1:0]  pixel_y;
    logic [`DBG_BRIGHT_W-1:0] pixel_brightness;
    logic                     tx_line;

    logic [7:0]           rx_q[$];          // Received characters, oldest first
    logic                 quiet;            // Line must stay idle while set
    logic [31:0]          rng = 32'hc508_7ccf;
    int                   frame_no = 0;     // Frame ticks seen by the DUT
    int                   valid_n;
    int                   cycle_cnt = 0;
    int                   mismatch_cnt = 0; // Main process only
    int                   misc_cnt = 0;
    int                   bit_err_cnt = 0;  // Monitor only
    int                   idle_err_cnt = 0; // Idle assertion only
    dbg_pkg::frame_snap_t exp_frame;
    dbg_pkg::pixel_snap_t exp_pix;

    serial_debug #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut (
        .i_clk              (clk),
        .i_rst_n            (rst_n),
        .i_enable           (enable),
        .i_frame_tick       (frame_tick),
        .i_pixel_valid      (pixel_valid),
        .i_cpu_pc           (cpu_pc),
        .i_cpu_instr_count  (cpu_instr_count),
        .i_cpu_running      (cpu_running),
        .i_pixel_strobe     (pixel_strobe),
        .i_pixel_count      (pixel_count),
        .i_pixel_x          (pixel_x),
        .i_pixel_y          (pixel_y),
        .i_pixel_brightness (pixel_brightness),
        .o_uart_tx          (tx_line)
    );

    always #5 clk = ~clk;  // 10 ns period

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Upper case hex, most significant digit first
    function automatic string hex_str(input logic [31:0] v, input int n);
        string digits;
        string s;
        int    idx;
        digits = "0123456789ABCDEF";
        s = "";
        for (int i = n - 1; i >= 0; i--) begin
            idx = int'(v[4*i +: 4]);
            s = {s, digits.substr(idx, idx)};
        end
        return s;
    endfunction

    function automatic string frame_text(input dbg_pkg::frame_snap_t f);
        string run_txt;
        if (f.running) run_txt = " R";
        else run_txt = " .";
        return {"F:", hex_str(32'(f.frame), 4), " PC:", hex_str(32'(f.pc), 3),
                " I:", hex_str(32'(f.instr), 4), " V:", hex_str(32'(f.valid_cnt), 4),
                run_txt, "\015\012"};
    endfunction

    function automatic string pixel_text(input dbg_pkg::pixel_snap_t p);
        return {"P:", hex_str(32'(p.count), 5), " X:", hex_str(32'(p.x), 3),
                " Y:", hex_str(32'(p.y), 3), " B:", hex_str(32'(p.bright), 1), "\015\012"};
    endfunction

    // Call right after a rising edge, tick seen by the DUT on the next one
    task automatic start_frame_tick(input int vcnt);
        rng = xorshift32(rng);
        exp_frame.frame     = 16'(frame_no);
        exp_frame.pc        = rng[11:0];
        exp_frame.instr     = rng[27:12];
        exp_frame.valid_cnt = 16'(vcnt);
        exp_frame.running   = rng[31];
        cpu_pc          <= exp_frame.pc;
        cpu_instr_count <= exp_frame.instr;
        cpu_running     <= exp_frame.running;
        frame_tick      <= 1'b1;
        frame_no++;
    endtask

    task automatic start_pixel_strobe();
        rng = xorshift32(rng);
        exp_pix.count = rng[19:0] | 20'hA0000;       // Top digit A, B, E or F
        exp_pix.x     = rng[29:20] | 10'h0C0;        // Middle digit C to F
        rng = xorshift32(rng);
        exp_pix.y      = rng[9:0];
        exp_pix.bright = rng[12:10];
        pixel_count      <= exp_pix.count;
        pixel_x          <= exp_pix.x;
        pixel_y          <= exp_pix.y;
        pixel_brightness <= exp_pix.bright;
        pixel_strobe     <= 1'b1;
    endtask

    task automatic end_pulses();
        @(posedge clk);
        frame_tick   <= 1'b0;
        pixel_strobe <= 1'b0;
    endtask

    // Waits for a whole line, then compares it char by char
    task automatic check_line(input string name, input string exp);
        logic [7:0] got;
        while (rx_q.size() < exp.len()) @(posedge clk);
        for (int i = 0; i < exp.len(); i++) begin
            got = rx_q.pop_front();
            assert (got == exp[i]) else begin
                $display("mismatch %s char %0d: expected 0x%02h actual 0x%02h",
                         name, i, exp[i], got);
                mismatch_cnt++;
            end
        end
    endtask

    task automatic print_counts();
        $display("mismatches: %0d, other errors: %0d",
                 mismatch_cnt, misc_cnt + bit_err_cnt + idle_err_cnt);
    endtask

    // ============================================================
    // UART receive monitor and idle check
    // ============================================================
    initial begin : uart_monitor
        logic [7:0] data;
        forever begin
            @(negedge clk);
            if (rst_n && tx_line == 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Mid start bit
                assert (tx_line == 1'b0) else begin
                    $display("start bit too short at %0t", $time);
                    bit_err_cnt++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    data[i] = tx_line;                      // LSB first
                end
                repeat (CLKS_PER_BIT) @(negedge clk);       // Mid stop bit
                assert (tx_line == 1'b1) else begin
                    $display("stop bit low at %0t", $time);
                    bit_err_cnt++;
                end
                rx_q.push_back(data);
            end
        end
    end

    assert property (@(negedge clk) disable iff (!rst_n) quiet |-> tx_line) else begin
        $display("line left idle while no report was allowed, at %0t", $time);
        idle_err_cnt++;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a report never completed", cycle_cnt);
            print_counts();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin
        rst_n            <= 1'b0;
        enable           <= 1'b1;
        frame_tick       <= 1'b0;
        pixel_valid      <= 1'b0;
        cpu_pc           <= '0;
        cpu_instr_count  <= '0;
        cpu_running      <= 1'b0;
        pixel_strobe     <= 1'b0;
        pixel_count      <= '0;
        pixel_x          <= '0;
        pixel_y          <= '0;
        pixel_brightness <= '0;
        quiet            <= 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Reset and idle
        repeat (100) @(posedge clk);
        assert (rx_q.size() == 0) else begin
            $display("characters received with no trigger after reset");
            misc_cnt++;
        end
        quiet <= 1'b0;

        // Frame report, first line then one with N valid cycles
        @(posedge clk);
        start_frame_tick(0);
        end_pulses();
        check_line("frame first", frame_text(exp_frame));
        rng = xorshift32(rng);
        valid_n = 1 + int'(rng[5:0]);
        repeat (valid_n) begin
            @(posedge clk);
            pixel_valid <= 1'b1;
        end
        @(posedge clk);
        pixel_valid <= 1'b0;
        @(posedge clk);
        start_frame_tick(valid_n);
        end_pulses();
        check_line("frame valid", frame_text(exp_frame));

        // Pixel report
        @(posedge clk);
        start_pixel_strobe();
        end_pulses();
        check_line("pixel", pixel_text(exp_pix));

        // Same cycle triggers, pixel line goes first
        @(posedge clk);
        start_frame_tick(0);
        start_pixel_strobe();
        end_pulses();
        check_line("priority pixel", pixel_text(exp_pix));
        check_line("priority frame", frame_text(exp_frame));

        // Enable gate, counter keeps running while disabled
        @(posedge clk);
        enable <= 1'b0;
        quiet  <= 1'b1;
        @(posedge clk);
        start_frame_tick(0);
        start_pixel_strobe();
        end_pulses();
        repeat (200) @(posedge clk);
        assert (rx_q.size() == 0) else begin
            $display("characters received while enable was low");
            misc_cnt++;
        end
        enable <= 1'b1;
        quiet  <= 1'b0;
        repeat (5) @(posedge clk);
        start_frame_tick(0);
        end_pulses();
        check_line("enable frame", frame_text(exp_frame));

        repeat (20 * CLKS_PER_BIT) @(posedge clk);  // Two byte times
        assert (rx_q.size() == 0) else begin
            $display("extra characters after the last report");
            misc_cnt++;
        end

        print_counts();
        if (mismatch_cnt + misc_cnt + bit_err_cnt + idle_err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+source
source/dbg_pkg.sv
source/frame_stats.sv
source/snapshot_slot.sv
source/msg_formatter.sv
source/uart_tx.sv
source/serial_debug.sv
sim/tb_serial_debug.sv

// File: Makefile
SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_serial_debug
RTL_TOP   := serial_debug
FILELIST  := sim.f
BUILD_DIR := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only if the simulation printed the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(SIM) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
